// ==== verilog/lock_cfg.svh ====
`ifndef LOCK_CFG_SVH
`define LOCK_CFG_SVH

// channel count and datapath widths
`define LOCK_N_CHAN 4     // output channels behind the distributor
`define LOCK_W_IN 32      // pid sum width
`define LOCK_W_OUT 16     // dac word width
`define LOCK_W_MLT 8      // per-channel multiplier width

// front-panel values after reset
`define LOCK_MAX_INIT 26214     // upper output bound
`define LOCK_MIN_INIT (-26214)  // lower output bound
`define LOCK_OUT_INIT 0         // starting output value
`define LOCK_MULT_INIT 1        // unity scaling

`endif

// ==== verilog/lock_sample_pkg.sv ====
`default_nettype none

`include "lock_cfg.svh"

package lock_sample_pkg;

	typedef logic [$clog2(`LOCK_N_CHAN)-1:0] chan_t;   // channel number
	typedef logic signed [`LOCK_W_IN-1:0] pid_sum_t;    // incoming pid sum
	typedef logic signed [`LOCK_W_OUT-1:0] out_word_t;  // dac output word

	// input stream payload
	typedef struct packed {
		chan_t chan;     // target channel
		pid_sum_t sum;   // sum for that channel
	} pid_req_t;

	// output stream payload
	typedef struct packed {
		chan_t chan;      // source channel
		out_word_t word;  // clamped result
	} dac_word_t;

endpackage

`default_nettype wire

// ==== verilog/lock_panel_pkg.sv ====
`default_nettype none

`include "lock_cfg.svh"

package lock_panel_pkg;

	// max, min and init share the output word format
	typedef logic signed [`LOCK_W_OUT-1:0] bound_t;

	// gain applied to each pid sum, always positive
	typedef logic [`LOCK_W_MLT-1:0] mult_t;

endpackage

`default_nettype wire

// ==== verilog/stream_slice.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_slice #(
	parameter type payload_t = logic  // carried word
) (
	input  wire logic clk_in,
	input  wire logic reset_in,
	input  wire logic in_valid,       // upstream has a word
	output logic in_ready,            // slot free or draining
	input  payload_t in_data,
	output logic out_valid,           // slot holds a word
	input  wire logic out_ready,      // downstream takes it
	output payload_t out_data
);

	logic full_q;   // slot occupied
	logic live_q;   // out of reset
	logic load;     // upstream transfer

	assign in_ready = live_q & (~full_q | out_ready);  // empty or emptied this edge
	assign load = in_valid & in_ready;
	assign out_valid = full_q;

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			full_q <= 1'b0;
			live_q <= 1'b0;
		end else begin
			live_q <= 1'b1;
			if (load) begin
				full_q <= 1'b1;       // refill wins over drain
			end else if (out_ready) begin
				full_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_in) begin
		if (load) begin
			out_data <= in_data;  // payload register
		end
	end

endmodule

`default_nettype wire

// ==== verilog/chan_distributor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lock_cfg.svh"

module chan_distributor
	import lock_sample_pkg::*;
(
	// sample path from the input slice
	input  wire logic req_valid,
	output logic req_ready,                      // ready of the addressed channel
	input  chan_t req_chan,
	output logic [`LOCK_N_CHAN-1:0] chan_valid,  // one-hot valid
	input  wire logic [`LOCK_N_CHAN-1:0] chan_ready,

	// parameter update path
	input  wire logic update,       // load strobe from the panel
	input  wire logic update_en,    // qualifies the strobe
	input  chan_t update_chan,
	output logic [`LOCK_N_CHAN-1:0] upd_pulse
);

	logic upd_fire;  // qualified update

	assign upd_fire = update & update_en;

	//////////////////////////////////////////////////
	// channel decode
	//////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < `LOCK_N_CHAN; i++) begin
			chan_valid[i] = req_valid && (req_chan == chan_t'(i));    // steer sample
			upd_pulse[i] = upd_fire && (update_chan == chan_t'(i));   // steer update
		end
	end

	// ready comes back only from the channel being addressed
	assign req_ready = chan_ready[req_chan];

endmodule

`default_nettype wire

// ==== verilog/output_preprocessor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lock_cfg.svh"

module output_preprocessor
	import lock_sample_pkg::*;
	import lock_panel_pkg::*;
(
	input  wire logic clk_in,
	input  wire logic reset_in,

	// sample stream from the distributor
	input  wire logic in_valid,
	output logic in_ready,        // idle only
	input  pid_sum_t pid_sum,
	input  wire logic lock_en,    // off selects init

	// front-panel parameters
	input  wire logic upd_pulse,  // reload for this channel
	input  bound_t panel_max,
	input  bound_t panel_min,
	input  bound_t panel_init,
	input  mult_t panel_mult,

	// result toward the arbiter
	output logic res_valid,       // result held
	input  wire logic res_ready,  // granted this cycle
	output out_word_t res_data
);

	// headroom for product plus previous value
	localparam int W_CALC = `LOCK_W_IN + `LOCK_W_MLT + 2;

	typedef logic signed [W_CALC-1:0] calc_t;

	bound_t max_q;      // active upper bound
	bound_t min_q;      // active lower bound
	bound_t init_q;     // active init value
	mult_t mult_q;      // active multiplier
	out_word_t prev_q;  // last delivered output

	calc_t scaled;      // sum times multiplier
	calc_t summed;      // plus previous output
	calc_t selected;    // after lock select
	calc_t clip_hi;     // after max clamp
	calc_t clip_lo;     // after min clamp
	out_word_t next_word;

	logic accept;       // sample taken
	logic deliver;      // result taken

	assign in_ready = ~res_valid;
	assign accept = in_valid & in_ready;
	assign deliver = res_valid & res_ready;

	//////////////////////////////////////////////////
	// datapath
	//////////////////////////////////////////////////

	assign scaled = calc_t'(pid_sum) * calc_t'($signed({1'b0, mult_q}));  // mult is unsigned
	assign summed = scaled + calc_t'(prev_q);
	assign selected = lock_en ? summed : calc_t'(init_q);
	assign clip_hi = (selected > calc_t'(max_q)) ? calc_t'(max_q) : selected;
	assign clip_lo = (clip_hi < calc_t'(min_q)) ? calc_t'(min_q) : clip_hi;
	assign next_word = out_word_t'(clip_lo);  // in range after clamp

	//////////////////////////////////////////////////
	// result hold
	//////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			res_valid <= 1'b0;
		end else if (accept) begin
			res_valid <= 1'b1;    // one cycle after acceptance
		end else if (deliver) begin
			res_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk_in) begin
		if (accept) begin
			res_data <= next_word;
		end
	end

	// previous output follows each delivered word
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			prev_q <= out_word_t'(`LOCK_OUT_INIT);
		end else if (upd_pulse) begin
			prev_q <= panel_init;  // restart from new init
		end else if (deliver) begin
			prev_q <= res_data;
		end
	end

	//////////////////////////////////////////////////
	// parameter registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			max_q <= bound_t'(`LOCK_MAX_INIT);
			min_q <= bound_t'(`LOCK_MIN_INIT);
			init_q <= bound_t'(`LOCK_OUT_INIT);
			mult_q <= mult_t'(`LOCK_MULT_INIT);
		end else if (upd_pulse) begin
			max_q <= panel_max;
			min_q <= panel_min;
			init_q <= panel_init;
			mult_q <= panel_mult;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/dac_word_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lock_cfg.svh"

module dac_word_arbiter
	import lock_sample_pkg::*;
(
	input  wire logic clk_in,
	input  wire logic reset_in,
	input  wire logic [`LOCK_N_CHAN-1:0] res_valid,  // held results
	input  out_word_t res_data [`LOCK_N_CHAN],
	output logic [`LOCK_N_CHAN-1:0] res_ready,       // pulse to the granted channel
	output logic dac_valid,
	input  wire logic dac_ready,
	output chan_t dac_chan,
	output out_word_t dac_data
);

	chan_t rr_ptr;        // first channel to consider
	chan_t grant_chan;    // winner this cycle
	logic grant_found;    // any channel waiting
	logic slot_ready;     // output slice can accept
	logic slot_take;      // word moves into the slice
	dac_word_t slot_word;
	dac_word_t dac_word;

	//////////////////////////////////////////////////
	// round-robin search
	//////////////////////////////////////////////////

	always_comb begin : grant_search
		int idx;
		grant_found = 1'b0;
		grant_chan = '0;
		for (int k = 0; k < `LOCK_N_CHAN; k++) begin
			idx = (int'(rr_ptr) + k) % `LOCK_N_CHAN;   // wrap past last channel
			if (!grant_found && res_valid[idx]) begin
				grant_found = 1'b1;
				grant_chan = chan_t'(idx);
			end
		end
	end

	assign slot_take = grant_found & slot_ready;
	assign res_ready = slot_take ? (`LOCK_N_CHAN)'(1) << grant_chan : '0;
	assign slot_word = '{chan: grant_chan, word: res_data[grant_chan]};

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			rr_ptr <= '0;
		end else if (slot_take) begin
			rr_ptr <= chan_t'((int'(grant_chan) + 1) % `LOCK_N_CHAN);  // start after winner
		end
	end

	stream_slice #(
		.payload_t(dac_word_t)
	) i_dac_slice (
		.clk_in   (clk_in),
		.reset_in (reset_in),
		.in_valid (grant_found),
		.in_ready (slot_ready),
		.in_data  (slot_word),
		.out_valid(dac_valid),
		.out_ready(dac_ready),
		.out_data (dac_word)
	);

	assign dac_chan = dac_word.chan;
	assign dac_data = dac_word.word;

endmodule

`default_nettype wire

// ==== verilog/lock_output_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lock_cfg.svh"

module lock_output_top
	import lock_sample_pkg::*;
	import lock_panel_pkg::*;
(
	input  wire logic clk_in,
	input  wire logic reset_in,
	input  wire logic sum_valid,     // pid sum stream
	output logic sum_ready,
	input  chan_t sum_chan,
	input  pid_sum_t sum_data,
	input  wire logic lock_en,       // shared by all channels
	input  wire logic update,        // panel load strobe
	input  wire logic update_en,
	input  chan_t update_chan,
	input  bound_t panel_max,
	input  bound_t panel_min,
	input  bound_t panel_init,
	input  mult_t panel_mult,
	output logic dac_valid,          // tagged dac stream
	input  wire logic dac_ready,
	output chan_t dac_chan,
	output out_word_t dac_data
);

	pid_req_t sum_word;       // input payload
	pid_req_t req_word;       // registered payload
	logic req_valid;
	logic req_ready;
	logic [`LOCK_N_CHAN-1:0] chan_valid;
	logic [`LOCK_N_CHAN-1:0] chan_ready;
	logic [`LOCK_N_CHAN-1:0] upd_pulse;
	logic [`LOCK_N_CHAN-1:0] res_valid;
	logic [`LOCK_N_CHAN-1:0] res_ready;
	out_word_t res_data [`LOCK_N_CHAN];

	assign sum_word = '{chan: sum_chan, sum: sum_data};

	stream_slice #(
		.payload_t(pid_req_t)
	) i_sum_slice (
		.clk_in   (clk_in),
		.reset_in (reset_in),
		.in_valid (sum_valid),
		.in_ready (sum_ready),
		.in_data  (sum_word),
		.out_valid(req_valid),
		.out_ready(req_ready),
		.out_data (req_word)
	);

	chan_distributor i_chan_distributor (
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.req_chan   (req_word.chan),
		.chan_valid (chan_valid),
		.chan_ready (chan_ready),
		.update     (update),
		.update_en  (update_en),
		.update_chan(update_chan),
		.upd_pulse  (upd_pulse)
	);

	//////////////////////////////////////////////////
	// one preprocessor per channel
	//////////////////////////////////////////////////

	for (genvar i = 0; i < `LOCK_N_CHAN; i++) begin : g_chan
		output_preprocessor i_output_preprocessor (
			.clk_in    (clk_in),
			.reset_in  (reset_in),
			.in_valid  (chan_valid[i]),
			.in_ready  (chan_ready[i]),
			.pid_sum   (req_word.sum),     // broadcast, valid selects
			.lock_en   (lock_en),
			.upd_pulse (upd_pulse[i]),
			.panel_max (panel_max),
			.panel_min (panel_min),
			.panel_init(panel_init),
			.panel_mult(panel_mult),
			.res_valid (res_valid[i]),
			.res_ready (res_ready[i]),
			.res_data  (res_data[i])
		);
	end

	dac_word_arbiter i_dac_word_arbiter (
		.clk_in   (clk_in),
		.reset_in (reset_in),
		.res_valid(res_valid),
		.res_data (res_data),
		.res_ready(res_ready),
		.dac_valid(dac_valid),
		.dac_ready(dac_ready),
		.dac_chan (dac_chan),
		.dac_data (dac_data)
	);

endmodule

`default_nettype wire

// ==== verif/lock_output_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lock_cfg.svh"

module lock_output_monitor
	import lock_sample_pkg::*;
(
	input  wire logic clk_in,
	input  wire logic reset_in,
	input  wire logic dac_valid,
	input  wire logic dac_ready,
	input  chan_t dac_chan,
	input  out_word_t dac_data
);

	out_word_t exp_q [`LOCK_N_CHAN][$];  // expected words, one queue per channel
	int checked_count = 0;               // words compared
	int err_count = 0;                   // mismatches and strays

	task automatic push_expect(input chan_t chan, input out_word_t word);
		exp_q[chan].push_back(word);
	endtask

	function automatic int pending();
		int total;
		total = 0;
		for (int c = 0; c < `LOCK_N_CHAN; c++) begin
			total += exp_q[c].size();
		end
		return total;
	endfunction

	//////////////////////////////////////////////////
	// compare on each dac transfer
	//////////////////////////////////////////////////

	// transfer lands on the next rising edge
	always @(negedge clk_in) begin : compare_word
		out_word_t want;
		if (!reset_in && dac_valid && dac_ready) begin
			if (exp_q[dac_chan].size() == 0) begin
				$display("unexpected dac word %h on channel %0d with nothing pending",
					dac_data, dac_chan);
				err_count++;
			end else begin
				want = exp_q[dac_chan].pop_front();  // in order within a channel
				checked_count++;
				if (dac_data !== want) begin
					$display("Error: dac_data on channel %0d got 0x%h expected 0x%h",
						dac_chan, dac_data, want);
					err_count++;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== verif/lock_output_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lock_cfg.svh"

module lock_output_chk
	import lock_sample_pkg::*;
	import lock_panel_pkg::*;
(
	input  wire logic clk_in,
	input  wire logic reset_in,
	input  wire logic sum_valid,
	input  wire logic sum_ready,
	input  chan_t sum_chan,
	input  pid_sum_t sum_data,
	input  wire logic update,
	input  wire logic update_en,
	input  chan_t update_chan,
	input  bound_t panel_max,
	input  bound_t panel_min,
	input  wire logic dac_valid,
	input  wire logic dac_ready,
	input  chan_t dac_chan,
	input  out_word_t dac_data
);

	bound_t max_r [`LOCK_N_CHAN];  // bounds in force per channel
	bound_t min_r [`LOCK_N_CHAN];
	int fail_count = 0;            // failed assertions

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			for (int i = 0; i < `LOCK_N_CHAN; i++) begin
				max_r[i] <= bound_t'(`LOCK_MAX_INIT);
				min_r[i] <= bound_t'(`LOCK_MIN_INIT);
			end
		end else if (update && update_en) begin
			max_r[update_chan] <= panel_max;  // qualified load only
			min_r[update_chan] <= panel_min;
		end
	end

	//////////////////////////////////////////////////
	// handshake and range properties
	//////////////////////////////////////////////////

	sum_hold: assert property (@(posedge clk_in) disable iff (reset_in)
		sum_valid && !sum_ready |=> sum_valid && $stable(sum_chan) && $stable(sum_data))
	else begin
		fail_count++;
		$error("sum stream dropped or changed its word while stalled");
	end

	dac_hold: assert property (@(posedge clk_in) disable iff (reset_in)
		dac_valid && !dac_ready |=> dac_valid && $stable(dac_chan) && $stable(dac_data))
	else begin
		fail_count++;
		$error("dac stream dropped or changed its word while stalled");
	end

	dac_range: assert property (@(posedge clk_in) disable iff (reset_in)
		dac_valid |-> dac_data <= max_r[dac_chan] && dac_data >= min_r[dac_chan])
	else begin
		fail_count++;
		$error("dac word outside the loaded bounds of its channel");
	end

	reset_quiet: assert property (@(posedge clk_in)
		$past(reset_in) |-> !dac_valid && !sum_ready)
	else begin
		fail_count++;
		$error("stream handshake active during reset");
	end

endmodule

bind lock_output_top lock_output_chk i_lock_output_chk (.*);

`default_nettype wire

// ==== verif/lock_output_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lock_cfg.svh"

module lock_output_tb
	import lock_sample_pkg::*;
	import lock_panel_pkg::*;
();

	localparam string PATTERN_FILE = "verif/lock_output_patterns.txt";

	logic clk_in;
	logic reset_in;
	logic sum_valid;
	logic sum_ready;
	chan_t sum_chan;
	pid_sum_t sum_data;
	logic lock_en;
	logic update;
	logic update_en;
	chan_t update_chan;
	bound_t panel_max;
	bound_t panel_min;
	bound_t panel_init;
	mult_t panel_mult;
	logic dac_valid;
	logic dac_ready;
	chan_t dac_chan;
	out_word_t dac_data;

	int cycles = 0;        // clock edges so far
	int cycle_limit = 0;   // 40 per pattern line
	int n_tests = 0;
	int n_failed = 0;
	int format_errs = 0;   // unreadable pattern lines
	int err_mark = 0;      // error total at test start
	int word_mark = 0;     // checked words at test start

	lock_output_top i_lock_output_top (.*);

	lock_output_monitor i_monitor (
		.clk_in   (clk_in),
		.reset_in (reset_in),
		.dac_valid(dac_valid),
		.dac_ready(dac_ready),
		.dac_chan (dac_chan),
		.dac_data (dac_data)
	);

	initial begin
		clk_in = 1'b0;
		forever #10 clk_in = ~clk_in;  // 20 ns period
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] next_random(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int error_total();
		return i_monitor.err_count + i_lock_output_top.i_lock_output_chk.fail_count;
	endfunction

	function automatic int count_lines();
		int fd;
		int n;
		string line;
		n = 0;
		fd = $fopen(PATTERN_FILE, "r");
		if (fd != 0) begin
			while ($fgets(line, fd) != 0) begin
				n++;
			end
			$fclose(fd);
		end
		return n;
	endfunction

	// back to the drive slot once every expected word is out
	task automatic wait_drained();
		while (i_monitor.pending() != 0) begin
			@(negedge clk_in);
		end
		@(posedge clk_in);
		#2;
	endtask

	task automatic send_sum(input int chan_v, input int sum_v);
		sum_valid = 1'b1;
		sum_chan = chan_t'(chan_v);
		sum_data = pid_sum_t'(sum_v);
		do begin
			@(negedge clk_in);
		end while (!sum_ready);  // transfer on the coming edge
		@(posedge clk_in);
		#2;
		sum_valid = 1'b0;
	endtask

	task automatic apply_update(input int chan_v, input int max_v, input int min_v,
			input int init_v, input int mult_v, input int en_v);
		update = 1'b1;
		update_en = (en_v != 0);
		update_chan = chan_t'(chan_v);
		panel_max = bound_t'(max_v);
		panel_min = bound_t'(min_v);
		panel_init = bound_t'(init_v);
		panel_mult = mult_t'(mult_v);
		@(posedge clk_in);
		#2;
		update = 1'b0;  // single cycle strobe
		update_en = 1'b0;
	endtask

	task automatic finish_test(input int test_v);
		int errs;
		int words;
		errs = error_total() - err_mark;
		words = i_monitor.checked_count - word_mark;
		n_tests++;
		if (errs != 0) begin
			n_failed++;
			$display("test %0d bad: %0d words checked, %0d errors", test_v, words, errs);
		end else begin
			$display("test %0d ok: %0d words checked", test_v, words);
		end
		err_mark = error_total();
		word_mark = i_monitor.checked_count;
	endtask

	task automatic play_patterns();
		int fd;
		int n_read;
		int n_want;
		int test_v, chan_v, lock_v, sum_v, exp_v;
		int max_v, min_v, init_v, mult_v, en_v;
		byte tag;
		string line;
		fd = $fopen(PATTERN_FILE, "r");
		while ($fgets(line, fd) != 0) begin
			tag = line.getc(0);  // comment and blank lines fall through
			if (tag == "U") begin
				n_want = 6;
				n_read = $sscanf(line.substr(1, line.len() - 1), "%d %d %d %d %d %d",
					chan_v, max_v, min_v, init_v, mult_v, en_v);
				wait_drained();     // no word in flight across a reload
				apply_update(chan_v, max_v, min_v, init_v, mult_v, en_v);
			end else if (tag == "S") begin
				n_want = 5;
				n_read = $sscanf(line.substr(1, line.len() - 1), "%d %d %d %d %d",
					test_v, chan_v, lock_v, sum_v, exp_v);
				if ((lock_v != 0) != lock_en) begin
					wait_drained();  // lock_en sampled at acceptance
					lock_en = (lock_v != 0);
				end
				i_monitor.push_expect(chan_t'(chan_v), out_word_t'(exp_v));
				send_sum(chan_v, sum_v);
			end else if (tag == "E") begin
				n_want = 1;
				n_read = $sscanf(line.substr(1, line.len() - 1), "%d", test_v);
				wait_drained();
				finish_test(test_v);
			end else begin
				n_want = -1;
				n_read = -1;
			end
			if (n_read != n_want) begin
				$display("pattern line could not be read: %s", line);
				format_errs++;
			end
		end
		$fclose(fd);
	endtask

	//////////////////////////////////////////////////
	// stimulus and verdict
	//////////////////////////////////////////////////

	initial begin : ready_toggle
		logic [31:0] rnd;
		rnd = 32'h2524cc07;
		dac_ready = 1'b0;
		forever begin
			@(posedge clk_in);
			#2;
			rnd = next_random(rnd);
			dac_ready = (rnd[17:16] != 2'b00);  // ready about three cycles in four
		end
	end

	always @(posedge clk_in) begin
		cycles++;
		if (cycle_limit != 0 && cycles > cycle_limit) begin
			$display("timeout after %0d cycles with %0d results still outstanding",
				cycles, i_monitor.pending());
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	initial begin : main
		int n_lines;
		int n_errors;
		reset_in = 1'b1;
		sum_valid = 1'b0;
		sum_chan = '0;
		sum_data = '0;
		lock_en = 1'b1;
		update = 1'b0;
		update_en = 1'b0;
		update_chan = '0;
		panel_max = '0;
		panel_min = '0;
		panel_init = '0;
		panel_mult = '0;
		n_lines = count_lines();
		if (n_lines == 0) begin
			$display("pattern file %s is missing or empty", PATTERN_FILE);
			$display("SIMULATION FAILED");
			$finish;
		end else begin
			cycle_limit = 40 * n_lines;
			repeat (10) @(posedge clk_in);
			#2;
			reset_in = 1'b0;
			@(posedge clk_in);
			#2;
			play_patterns();
			n_errors = error_total() + format_errs;
			if (i_monitor.pending() != 0) begin
				$display("%0d expected dac words never arrived", i_monitor.pending());
				n_errors++;
			end
			if (i_monitor.checked_count == 0) begin
				$display("no dac words were checked");
				n_errors++;
			end
			$display("tests %0d, failed %0d, words checked %0d, errors %0d",
				n_tests, n_failed, i_monitor.checked_count, n_errors);
			if (n_errors == 0 && n_failed == 0) begin
				$display("SIMULATION PASSED");
			end else begin
				$display("SIMULATION FAILED");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== verif/lock_output_patterns.txt ====
# U chan max min init mult en     panel load, en 0 keeps update_en low
# S test chan lock sum expected   one pid sum and the dac word it yields
# E test                          end of test, all results drained
# test 1 accumulate
U 0 1000 -1000 10 3 1
S 1 0 1 5 25
S 1 0 1 7 46
S 1 0 1 -4 34
S 1 1 1 40 40
S 1 0 1 100 334
S 1 1 1 -15 25
E 1
# test 2 clamp
S 2 0 1 1000000 1000
S 2 0 1 -1000000 -1000
S 2 0 1 200 -400
S 2 0 1 2147483647 1000
S 2 0 1 -2147483648 -1000
S 2 1 1 100000 26214
S 2 1 1 -100000 -26214
E 2
# test 3 lock off and new init
S 3 0 0 12345 10
S 3 0 0 -999 10
U 2 2000 -2000 -50 2 1
S 3 2 1 30 10
S 3 2 1 5 20
S 3 2 0 777 -50
S 3 2 1 -10 -70
E 3
# test 4 interleaved channels
U 3 500 -500 100 4 1
U 1 30000 -30000 0 1 1
S 4 0 1 10 40
S 4 1 1 -200 -200
S 4 2 1 25 -20
S 4 3 1 7 128
S 4 0 1 -5 25
S 4 1 1 300 100
S 4 2 1 -1 -22
S 4 3 1 100 500
S 4 3 1 -300 -500
E 4
# test 5 bursts under back-pressure
S 5 1 1 1000 1100
S 5 1 1 1000 2100
S 5 0 1 100 325
S 5 3 1 50 -300
S 5 0 1 100 625
S 5 3 1 50 -100
S 5 2 1 1000 1978
S 5 1 1 -5000 -2900
E 5
# test 6 update without update_en
U 0 100 -100 0 1 0
U 3 0 0 0 0 0
S 6 0 1 100 925
S 6 0 1 50 1000
S 6 3 1 10 -60
S 6 0 1 -700 -1000
E 6

// ==== files.f ====
+incdir+verilog
verilog/lock_sample_pkg.sv
verilog/lock_panel_pkg.sv
verilog/stream_slice.sv
verilog/chan_distributor.sv
verilog/output_preprocessor.sv
verilog/dac_word_arbiter.sv
verilog/lock_output_top.sv
verif/lock_output_monitor.sv
verif/lock_output_chk.sv
verif/lock_output_tb.sv

// ==== Makefile ====
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module lock_output_tb -f files.f

sim:
	verilator --binary --timing --assert --top-module lock_output_tb -f files.f \
		-o lock_output_sim
	./obj_dir/lock_output_sim +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
